//--- verilog/spi_defines.svh
// Frame and register geometry shared by the RTL and the testbench
// Frame width must stay 32 since the bit counter is 5 bits wide
`ifndef SPI_DEFINES_SVH
`define SPI_DEFINES_SVH

`define SPI_FRAME_W      32 // command byte plus 3 data bytes
`define SPI_DATA_W       24
`define SPI_NUM_REGS     4
`define SPI_SYNC_STAGES  2  // flops before edge detection

`endif

//--- verilog/spi_pkg.sv
// Command and status layout of one 32-bit SPI frame, sent LSB first
// Byte 0 is the command or status byte, bytes 1 to 3 carry data
`include "spi_defines.svh"

package spi_pkg;

   typedef enum logic [3:0] {
      OP_NOP   = 4'd0,
      OP_READ  = 4'd1,
      OP_WRITE = 4'd2
   } spi_op_e;

   typedef logic [1:0] reg_addr_t;

   // Received word, opcode in the lowest nibble
   typedef struct packed {
      logic [`SPI_DATA_W-1:0] data;
      logic [1:0]             reserved; // ignored
      reg_addr_t              addr;
      logic [3:0]             opcode;   // raw field, may be illegal
   } spi_cmd_t;

   typedef struct packed {
      logic [3:0] opcode; // echoed
      reg_addr_t  addr;   // echoed
      logic       error;  // illegal opcode
      logic       valid;  // reply of a completed frame
   } spi_status_t;

endpackage

//--- verilog/spi_frame_if.sv
// Received frames and reply frames between shift engine and decoder
// Both strobes are single cycle, no back-pressure
`timescale 1ns/1ps
`include "spi_defines.svh"

interface spi_frame_if;

   logic                    rx_valid;
   logic [`SPI_FRAME_W-1:0] rx_frame; // valid with rx_valid
   logic                    tx_load;
   logic [`SPI_FRAME_W-1:0] tx_frame; // valid with tx_load

   modport engine (
      output rx_valid, rx_frame,
      input  tx_load, tx_frame
   );

   modport decoder (
      input  rx_valid, rx_frame,
      output tx_load, tx_frame
   );

endinterface

//--- verilog/reg_access_if.sv
// Decoder access to the register bank, rdata is combinational from addr
`timescale 1ns/1ps
`include "spi_defines.svh"

interface reg_access_if import spi_pkg::*; ();

   logic                   we;
   reg_addr_t              addr;
   logic [`SPI_DATA_W-1:0] wdata;
   logic [`SPI_DATA_W-1:0] rdata;

   modport master (output we, addr, wdata, input rdata);

   modport bank (input we, addr, wdata, output rdata);

endinterface

//--- verilog/spi_shift_engine.sv
// SPI mode 0 only, SCK half period must be at least 4 clk cycles
// A frame cut short by SS rising is dropped without a strobe
`timescale 1ns/1ps
`include "spi_defines.svh"

module spi_shift_engine (
   input  logic        clk,
   input  logic        reset,
   input  logic        sck,
   input  logic        ss_n,
   input  logic        mosi,
   output logic        miso,
   spi_frame_if.engine frame
);

   localparam int SYNC = `SPI_SYNC_STAGES;
   localparam int FW   = `SPI_FRAME_W;

   logic [SYNC:0]           sck_pipe; // top bit is the edge-detect flop
   logic [SYNC:0]           ss_pipe;
   logic [SYNC-1:0]         mosi_pipe;
   logic                    sck_s;
   logic                    ss_s;
   logic                    mosi_s;
   logic                    sck_rise;
   logic                    sck_fall;
   logic                    ss_rise;
   logic                    ss_fall;
   logic [$clog2(FW)-1:0]   bit_cnt;
   logic                    rx_valid_q;
   logic [FW-1:0]           rx_shift;
   logic [FW-1:0]           tx_shift;
   logic [FW-1:0]           tx_shadow; // last reply from the decoder

   always_ff @(posedge clk) begin
      if (reset) begin
         sck_pipe <= '0;
         ss_pipe  <= '1; // Deselected
      end else begin
         sck_pipe <= {sck_pipe[SYNC-1:0], sck};
         ss_pipe  <= {ss_pipe[SYNC-1:0], ss_n};
      end
   end

   always_ff @(posedge clk) begin
      mosi_pipe <= {mosi_pipe[SYNC-2:0], mosi};
   end

   assign sck_s  = sck_pipe[SYNC-1];
   assign ss_s   = ss_pipe[SYNC-1];
   assign mosi_s = mosi_pipe[SYNC-1]; // same depth as sck_s

   assign sck_rise = sck_s & ~sck_pipe[SYNC];
   assign sck_fall = ~sck_s & sck_pipe[SYNC];
   assign ss_rise  = ss_s & ~ss_pipe[SYNC];
   assign ss_fall  = ~ss_s & ss_pipe[SYNC];

   // Bit count, cleared at both SS edges so a short frame never completes
   always_ff @(posedge clk) begin
      if (reset) begin
         bit_cnt    <= '0;
         rx_valid_q <= 1'b0;
      end else begin
         rx_valid_q <= 1'b0;
         if (ss_rise || ss_fall) begin
            bit_cnt <= '0;
         end else if (sck_rise && !ss_s) begin
            bit_cnt    <= bit_cnt + 1'b1; // wraps after bit 31
            rx_valid_q <= (bit_cnt == FW - 1);
         end
      end
   end

   // LSB first, so bits enter at the top and move down
   always_ff @(posedge clk) begin
      if (sck_rise && !ss_s) begin
         rx_shift <= {mosi_s, rx_shift[FW-1:1]};
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         tx_shadow <= '0;
         tx_shift  <= '0;
      end else begin
         if (frame.tx_load) begin
            tx_shadow <= frame.tx_frame;
         end
         if (ss_fall) begin
            tx_shift <= tx_shadow;
         end else if (sck_fall && !ss_s) begin
            tx_shift <= {1'b0, tx_shift[FW-1:1]};
         end
      end
   end

   assign miso           = tx_shift[0];
   assign frame.rx_valid = rx_valid_q;
   assign frame.rx_frame = rx_shift;

   a_rx_valid_selected: assert property (@(posedge clk) disable iff (reset)
      frame.rx_valid |-> !ss_s);

   // SCK half period of at least 4 clk
   a_sck_half_period: assert property (@(posedge clk) disable iff (reset)
      (sck_rise || sck_fall) |-> !$past(sck_rise || sck_fall)
         && !$past(sck_rise || sck_fall, 2) && !$past(sck_rise || sck_fall, 3));

endmodule

//--- verilog/spi_cmd_decoder.sv
// Accepts every frame in one cycle, reply and write 1 clk after rx_valid
// Illegal opcodes are answered with the error bit and write nothing
`timescale 1ns/1ps
`include "spi_defines.svh"

module spi_cmd_decoder import spi_pkg::*; (
   input  logic         clk,
   input  logic         reset,
   spi_frame_if.decoder frame,
   reg_access_if.master regs
);

   spi_cmd_t               cmd_q;
   logic                   pending; // cmd_q holds a fresh frame
   logic                   is_write;
   logic                   is_legal;
   spi_status_t            status;
   logic [`SPI_DATA_W-1:0] reply_data;

   always_ff @(posedge clk) begin
      if (reset) begin
         pending <= 1'b0;
      end else begin
         pending <= frame.rx_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (frame.rx_valid) begin
         cmd_q <= spi_cmd_t'(frame.rx_frame);
      end
   end

   always_comb begin
      is_write = (cmd_q.opcode == OP_WRITE);
      is_legal = (cmd_q.opcode inside {OP_NOP, OP_READ, OP_WRITE});

      status.valid  = 1'b1;
      status.error  = ~is_legal;
      status.addr   = cmd_q.addr;
      status.opcode = cmd_q.opcode;

      // Register only updates at the end of this cycle
      if (is_write) begin
         reply_data = cmd_q.data;
      end else begin
         reply_data = regs.rdata;
      end
   end

   assign regs.addr  = cmd_q.addr;
   assign regs.wdata = cmd_q.data;
   assign regs.we    = pending & is_write;

   assign frame.tx_load  = pending;
   assign frame.tx_frame = {reply_data, status};

endmodule

//--- verilog/spi_reg_bank.sv
// Four registers with an SPI and a host write port
// SPI write wins when both ports hit the same address
`timescale 1ns/1ps
`include "spi_defines.svh"

module spi_reg_bank import spi_pkg::*; (
   input  logic                   clk,
   input  logic                   reset,
   reg_access_if.bank             regs,
   input  logic                   host_wr_en,
   input  reg_addr_t              host_wr_addr,
   input  logic [`SPI_DATA_W-1:0] host_wr_data,
   input  reg_addr_t              host_rd_addr,
   output logic [`SPI_DATA_W-1:0] host_rd_data,
   output logic                   spi_wr_strobe,
   output reg_addr_t              spi_wr_addr
);

   logic [`SPI_DATA_W-1:0] regs_q [`SPI_NUM_REGS];

   always_ff @(posedge clk) begin
      if (reset) begin
         regs_q        <= '{default: '0};
         spi_wr_strobe <= 1'b0;
      end else begin
         if (host_wr_en) begin
            regs_q[host_wr_addr] <= host_wr_data;
         end
         if (regs.we) begin
            regs_q[regs.addr] <= regs.wdata; // Last assignment wins
         end
         spi_wr_strobe <= regs.we; // same cycle as the new value
      end
   end

   always_ff @(posedge clk) begin
      if (regs.we) begin
         spi_wr_addr <= regs.addr;
      end
   end

   assign regs.rdata   = regs_q[regs.addr];
   assign host_rd_data = regs_q[host_rd_addr];

   // Notify strobe lines up with the stored SPI data, even under a host collision
   a_spi_write_visible: assert property (@(posedge clk) disable iff (reset)
      regs.we |=> spi_wr_strobe && (regs_q[spi_wr_addr] == $past(regs.wdata)));

endmodule

//--- verilog/spi_regs_top.sv
// SPI register peripheral, mode 0 frames of 32 bits sent LSB first
// Host ports are in the clk domain, SPI pins are asynchronous
`timescale 1ns/1ps
`include "spi_defines.svh"

module spi_regs_top import spi_pkg::*; (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   spi_sck,
   input  logic                   spi_ss_n,
   input  logic                   spi_mosi,
   output logic                   spi_miso,
   input  logic                   host_wr_en,
   input  reg_addr_t              host_wr_addr,
   input  logic [`SPI_DATA_W-1:0] host_wr_data,
   input  reg_addr_t              host_rd_addr,
   output logic [`SPI_DATA_W-1:0] host_rd_data,
   output logic                   spi_wr_strobe,
   output reg_addr_t              spi_wr_addr
);

   spi_frame_if  i_frame ();
   reg_access_if i_regs ();

   spi_shift_engine i_engine (
      .clk   (clk),
      .reset (reset),
      .sck   (spi_sck),
      .ss_n  (spi_ss_n),
      .mosi  (spi_mosi),
      .miso  (spi_miso),
      .frame (i_frame.engine)
   );

   spi_cmd_decoder i_decoder (
      .clk   (clk),
      .reset (reset),
      .frame (i_frame.decoder),
      .regs  (i_regs.master)
   );

   spi_reg_bank i_bank (
      .clk           (clk),
      .reset         (reset),
      .regs          (i_regs.bank),
      .host_wr_en    (host_wr_en),
      .host_wr_addr  (host_wr_addr),
      .host_wr_data  (host_wr_data),
      .host_rd_addr  (host_rd_addr),
      .host_rd_data  (host_rd_data),
      .spi_wr_strobe (spi_wr_strobe),
      .spi_wr_addr   (spi_wr_addr)
   );

endmodule

//--- test/tb_clock_gen.sv
// Free running clock, reset released 2 ns after the last reset edge
`timescale 1ns/1ps

module tb_clock_gen #(
   parameter int PERIOD       = 40,
   parameter int RESET_CYCLES = 5
) (
   output logic clk,
   output logic reset
);

   initial begin
      clk = 1'b0;
      forever #(PERIOD / 2) clk = ~clk;
   end

   initial begin
      reset = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      #2;
      reset = 1'b0;
   end

endmodule

//--- test/spi_regs_tb.sv
// Mode 0 SPI master model with an SCK half period of 6 clk
// Expected replies come from a register model built with the table
`timescale 1ns/1ps
`include "spi_defines.svh"

module spi_regs_tb import spi_pkg::*; ();

   localparam int NUM_ROWS    = 15;
   localparam int HALF        = 6; // SCK half period in clk cycles
   localparam int CYCLE_LIMIT = NUM_ROWS * `SPI_FRAME_W * 12 * 3 / 2;
   localparam int K_SPI       = 0;
   localparam int K_ABORT     = 1;
   localparam int K_HOST      = 2;

   logic                   clk;
   logic                   reset;
   logic                   spi_sck;
   logic                   spi_ss_n;
   logic                   spi_mosi;
   logic                   spi_miso;
   logic                   host_wr_en;
   reg_addr_t              host_wr_addr;
   logic [`SPI_DATA_W-1:0] host_wr_data;
   reg_addr_t              host_rd_addr;
   logic [`SPI_DATA_W-1:0] host_rd_data;
   logic                   spi_wr_strobe;
   reg_addr_t              spi_wr_addr;

   string                   row_name [NUM_ROWS];
   int                      row_kind [NUM_ROWS];
   logic [3:0]              row_op [NUM_ROWS];
   reg_addr_t               row_addr [NUM_ROWS];
   logic [`SPI_DATA_W-1:0]  row_data [NUM_ROWS];
   logic [`SPI_FRAME_W-1:0] row_reply [NUM_ROWS]; // reply to the previous frame
   logic [`SPI_DATA_W-1:0]  row_rd_data [NUM_ROWS];

   int                      row_idx = 0;
   int                      error_count = 0;
   int                      check_count = 0;
   int                      strobe_count = 0;
   int                      cycle_count = 0;
   reg_addr_t               last_strobe_addr;
   logic [31:0]             rand_state = 32'd37765;
   logic [`SPI_FRAME_W-1:0] rx_word;

   tb_clock_gen i_clk_gen (.clk(clk), .reset(reset));

   spi_regs_top i_dut (.*);

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      check_count++;
      if (actual !== expected) begin
         $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
         error_count++;
      end
   endtask

   task automatic next_cycle();
      @(posedge clk);
      #2;
   endtask

   task automatic set_row(input string name, input int kind, input logic [3:0] op,
                          input reg_addr_t addr);
      rand_state         = xorshift32(rand_state);
      row_name[row_idx]  = name;
      row_kind[row_idx]  = kind;
      row_op[row_idx]    = op;
      row_addr[row_idx]  = addr;
      row_data[row_idx]  = rand_state[`SPI_DATA_W-1:0];
      row_idx++;
   endtask

   task automatic build_table();
      logic [`SPI_DATA_W-1:0]  model [`SPI_NUM_REGS];
      logic [`SPI_FRAME_W-1:0] prev_reply;
      logic                    legal;
      set_row("first_read_zero", K_SPI, OP_READ, 2'd1);
      set_row("write_reg2", K_SPI, OP_WRITE, 2'd2);
      set_row("read_reg2", K_SPI, OP_READ, 2'd2);
      set_row("nop_reg0", K_SPI, OP_NOP, 2'd0);
      set_row("host_write_reg3", K_HOST, OP_NOP, 2'd3);
      set_row("read_host_reg3", K_SPI, OP_READ, 2'd3);
      set_row("write_reg0", K_SPI, OP_WRITE, 2'd0);
      set_row("illegal_op", K_SPI, 4'hA, 2'd0);
      set_row("read_after_illegal", K_SPI, OP_READ, 2'd0);
      set_row("write_reg1", K_SPI, OP_WRITE, 2'd1);
      set_row("abort_write_reg1", K_ABORT, OP_WRITE, 2'd1); // cut after 12 bits
      set_row("read_after_abort", K_SPI, OP_READ, 2'd1);
      set_row("host_write_reg1", K_HOST, OP_NOP, 2'd1);
      set_row("nop_reg1", K_SPI, OP_NOP, 2'd1);
      set_row("read_reg1", K_SPI, OP_READ, 2'd1);
      model      = '{default: '0};
      prev_reply = '0; // Shadow is clear after reset
      for (int i = 0; i < NUM_ROWS; i++) begin
         row_reply[i] = '0;
         if (row_kind[i] == K_HOST) begin
            model[row_addr[i]] = row_data[i];
         end else if (row_kind[i] == K_SPI) begin
            row_reply[i] = prev_reply;
            legal = (row_op[i] == 4'd0) || (row_op[i] == 4'd1) || (row_op[i] == 4'd2);
            if (row_op[i] == 4'd2)
               model[row_addr[i]] = row_data[i];
            // Data above status {opcode, addr, error, valid}
            prev_reply = {model[row_addr[i]], row_op[i], row_addr[i], ~legal, 1'b1};
         end
         row_rd_data[i] = model[row_addr[i]];
      end
   endtask

   // MISO is collected just before each SCK rising edge
   task automatic spi_frame(input logic [`SPI_FRAME_W-1:0] tx, input int bits,
                            output logic [`SPI_FRAME_W-1:0] rx);
      rx       = '0;
      spi_ss_n = 1'b0;
      for (int b = 0; b < bits; b++) begin
         spi_mosi = tx[b];
         repeat (HALF) next_cycle();
         rx[b]   = spi_miso;
         spi_sck = 1'b1;
         repeat (HALF) next_cycle();
         spi_sck = 1'b0;
      end
      repeat (HALF) next_cycle();
      spi_ss_n = 1'b1;
      repeat (10) next_cycle(); // SS high gap between frames
   endtask

   task automatic host_write(input reg_addr_t addr, input logic [`SPI_DATA_W-1:0] data);
      host_wr_en   = 1'b1;
      host_wr_addr = addr;
      host_wr_data = data;
      next_cycle();
      host_wr_en = 1'b0;
      next_cycle();
   endtask

   always @(negedge clk) begin
      if (!reset && spi_wr_strobe === 1'b1) begin
         strobe_count++;
         last_strobe_addr = spi_wr_addr;
      end
   end

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count > CYCLE_LIMIT) begin
         $display("Timeout: the run did not finish within %0d clk cycles", CYCLE_LIMIT);
         $display("Some tests failed");
         $finish;
      end
   end

   initial begin
      int   strobes_before;
      logic exp_strobe;
      spi_sck      = 1'b0;
      spi_ss_n     = 1'b1;
      spi_mosi     = 1'b0;
      host_wr_en   = 1'b0;
      host_wr_addr = '0;
      host_wr_data = '0;
      host_rd_addr = '0;
      build_table();
      while (reset !== 1'b0) next_cycle();
      repeat (2) next_cycle();
      for (int i = 0; i < NUM_ROWS; i++) begin
         strobes_before = strobe_count;
         case (row_kind[i])
            K_HOST: host_write(row_addr[i], row_data[i]);
            K_ABORT: spi_frame({row_data[i], 2'b00, row_addr[i], row_op[i]}, 12, rx_word);
            default: begin
               spi_frame({row_data[i], 2'b00, row_addr[i], row_op[i]}, 32, rx_word);
               check_value({row_name[i], " reply"}, row_reply[i], rx_word);
            end
         endcase
         exp_strobe = (row_kind[i] == K_SPI) && (row_op[i] == 4'd2);
         check_value({row_name[i], " strobe count"}, exp_strobe, strobe_count - strobes_before);
         if (exp_strobe)
            check_value({row_name[i], " strobe addr"}, row_addr[i], last_strobe_addr);
         host_rd_addr = row_addr[i];
         next_cycle();
         check_value({row_name[i], " host read"}, row_rd_data[i], host_rd_data);
      end
      $display("Checks run: %0d, errors: %0d", check_count, error_count);
      if (error_count == 0)
         $display("All tests passed");
      else
         $display("Some tests failed");
      $finish;
   end

endmodule

//--- flist.f
+incdir+verilog
verilog/spi_pkg.sv
verilog/spi_frame_if.sv
verilog/reg_access_if.sv
verilog/spi_shift_engine.sv
verilog/spi_cmd_decoder.sv
verilog/spi_reg_bank.sv
verilog/spi_regs_top.sv
test/tb_clock_gen.sv
test/spi_regs_tb.sv
